// File: design/cpuIntPkg.sv
package cpuIntPkg;

  typedef logic [7:0] opcodeT;
  typedef logic [8:0] statusT;

  // Status bit positions, E above the 8-bit P register.
  parameter int E_BIT = 8;
  parameter int N_BIT = 7;
  parameter int V_BIT = 6;
  parameter int M_BIT = 5;
  parameter int X_BIT = 4;
  parameter int D_BIT = 3;
  parameter int I_BIT = 2;
  parameter int Z_BIT = 1;
  parameter int C_BIT = 0;

  // Emulation mode, 8-bit A and index, IRQ masked.
  parameter statusT STATUS_RESET = 9'h134;

  parameter opcodeT OP_WAI = 8'hCB;
  parameter opcodeT OP_STP = 8'hDB;
  parameter opcodeT OP_XCE = 8'hFB;
  parameter opcodeT OP_REP = 8'hC2;
  parameter opcodeT OP_SEP = 8'hE2;
  parameter opcodeT OP_BRK = 8'h00;
  parameter opcodeT OP_COP = 8'h02;

  typedef enum logic [2:0]
  {
    INT_RESET,
    INT_NMI,
    INT_IRQ,
    INT_COP,
    INT_BRK
  } intKindT;

  typedef enum logic [1:0]
  {
    FETCH_IDLE,
    FETCH_LOW,
    FETCH_HIGH
  } fetchStateT;

endpackage

// File: design/statusReg.sv
`timescale 1ns/100ps

module statusReg
(
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              en,
  input  logic              instrEnd,
  input  cpuIntPkg::opcodeT opcode,
  input  cpuIntPkg::opcodeT operand,
  input  logic              takeInt,
  output cpuIntPkg::statusT status,
  output logic              branchTaken
);
  import cpuIntPkg::*;

  statusT nextStatus;
  opcodeT flagMask;
  logic   condFlag;
  logic   singleFlagOp;

  // TYA shares the xx18 pattern but leaves P alone.
  assign singleFlagOp = (opcode[4:0] == 5'h18) && (opcode != 8'h98);

  always_comb
  begin
    flagMask = operand;
    if (status[E_BIT])
    begin
      flagMask[M_BIT] = 1'b0; // Widths are locked in emulation.
      flagMask[X_BIT] = 1'b0;
    end
  end

  always_comb
  begin
    nextStatus = status;
    if (singleFlagOp)
    begin
      case (opcode[7:6])
        2'b00:   nextStatus[C_BIT] = opcode[5];
        2'b01:   nextStatus[I_BIT] = opcode[5];
        2'b10:   nextStatus[V_BIT] = 1'b0;
        default: nextStatus[D_BIT] = opcode[5];
      endcase
    end
    else if (opcode == OP_XCE)
    begin
      nextStatus[E_BIT] = status[C_BIT];
      nextStatus[C_BIT] = status[E_BIT];
      if (status[C_BIT])
      begin
        nextStatus[M_BIT] = 1'b1;
        nextStatus[X_BIT] = 1'b1;
      end
    end
    else if (opcode == OP_REP)
    begin
      nextStatus[7:0] = status[7:0] & ~flagMask;
    end
    else if (opcode == OP_SEP)
    begin
      nextStatus[7:0] = status[7:0] | flagMask;
    end
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      status <= STATUS_RESET;
    end
    else if (en)
    begin
      if (instrEnd)
        status <= nextStatus;
      // Interrupt entry overrides I and D from the last opcode.
      if (takeInt)
      begin
        status[I_BIT] <= 1'b1;
        status[D_BIT] <= 1'b0;
      end
    end
  end

  // Bits 7:6 pick the flag, bit 5 the polarity.
  always_comb
  begin
    case (opcode[7:6])
      2'b00:   condFlag = status[N_BIT];
      2'b01:   condFlag = status[V_BIT];
      2'b10:   condFlag = status[C_BIT];
      default: condFlag = status[Z_BIT];
    endcase
  end

  assign branchTaken = (opcode[4:0] == 5'h10) && (condFlag == opcode[5]);

  emuWidthLock: assert property (@(posedge CLK) disable iff (!RST_N)
    status[E_BIT] |-> (status[M_BIT] && status[X_BIT]))
    else $error("M or X cleared while in emulation mode");

endmodule

// File: design/pinWakeCtrl.sv
`timescale 1ns/100ps

module pinWakeCtrl
(
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              CE,
  input  logic              RDY_IN,
  input  logic              NMI_N,
  input  logic              IRQ_N,
  input  logic              ABORT_N,
  input  logic              instrEnd,
  input  cpuIntPkg::opcodeT opcode,
  input  logic              nmiAck,
  output logic              en,
  output logic              nmiPending,
  output logic              irqPending
);
  import cpuIntPkg::*;

  logic nmiLast;
  logic waiting;
  logic stopped;
  logic wakeReq;

  assign en = RDY_IN && CE && !waiting && !stopped;

  // Pin capture runs on CE alone, so it keeps going during WAI and STP.
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiLast    <= 1'b1;
      nmiPending <= 1'b0;
      irqPending <= 1'b0;
    end
    else if (CE)
    begin
      nmiLast    <= NMI_N;
      irqPending <= !IRQ_N; // Level, no latching.
      if (nmiAck && en)
        nmiPending <= 1'b0;
      if (nmiLast && !NMI_N)
        nmiPending <= 1'b1; // A new edge beats the ack.
    end
  end

  // WAI wakes on any source, whatever the I flag.
  assign wakeReq = nmiPending || irqPending || !ABORT_N;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      waiting <= 1'b0;
      stopped <= 1'b0;
    end
    else
    begin
      if (en && instrEnd)
      begin
        if (opcode == OP_WAI)
          waiting <= 1'b1;
        else if (opcode == OP_STP)
          stopped <= 1'b1; // Only RST_N leaves this.
      end
      if (CE && RDY_IN && waiting && wakeReq)
        waiting <= 1'b0;
    end
  end

  waitStopExcl: assert property (@(posedge CLK) disable iff (!RST_N)
    !(waiting && stopped))
    else $error("WAI and STP states active together");

endmodule

// File: design/vectorArbiter.sv
`timescale 1ns/100ps

module vectorArbiter
#(
  parameter int AddrW = 24
)
(
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              en,
  input  logic              instrEnd,
  input  cpuIntPkg::opcodeT opcode,
  input  cpuIntPkg::statusT status,
  input  logic              nmiPending,
  input  logic              irqPending,
  output logic              takeInt,
  output logic              nmiAck,
  output logic              VPB,
  output logic [AddrW-1:0]  vectorAddr
);
  import cpuIntPkg::*;

  typedef logic [AddrW-1:0] addrT;

  fetchStateT fetchState;
  intKindT    fetchKind;
  intKindT    nextKind;
  logic       fetchEmu;
  logic       irqTake;
  logic       softInt;
  logic [7:0] vecLow;
  logic [7:0] vecByte;

  assign irqTake = irqPending && !status[I_BIT];
  assign softInt = (opcode == OP_BRK) || (opcode == OP_COP);

  // Highest first: NMI, IRQ, COP, BRK.
  always_comb
  begin
    if (nmiPending)
      nextKind = INT_NMI;
    else if (irqTake)
      nextKind = INT_IRQ;
    else if (opcode == OP_COP)
      nextKind = INT_COP;
    else
      nextKind = INT_BRK;
  end

  assign takeInt = instrEnd && en && (fetchState == FETCH_IDLE) &&
                   (nmiPending || irqTake || softInt);
  assign nmiAck  = takeInt && (nextKind == INT_NMI);

  // Comes out of reset already fetching the reset vector.
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      fetchState <= FETCH_LOW;
      fetchKind  <= INT_RESET;
      fetchEmu   <= 1'b1;
      VPB        <= 1'b0;
    end
    else if (en)
    begin
      case (fetchState)
        FETCH_IDLE:
        begin
          if (takeInt)
          begin
            fetchState <= FETCH_LOW;
            fetchKind  <= nextKind;
            fetchEmu   <= status[E_BIT]; // Mode at the decision.
            VPB        <= 1'b0;
          end
        end
        FETCH_LOW:
          fetchState <= FETCH_HIGH;
        default:
        begin
          fetchState <= FETCH_IDLE;
          VPB        <= 1'b1;
        end
      endcase
    end
  end

  always_comb
  begin
    case (fetchKind)
      INT_RESET: vecLow = 8'hFC;
      INT_NMI:   vecLow = fetchEmu ? 8'hFA : 8'hEA;
      INT_IRQ:   vecLow = fetchEmu ? 8'hFE : 8'hEE;
      INT_COP:   vecLow = fetchEmu ? 8'hF4 : 8'hE4;
      default:   vecLow = fetchEmu ? 8'hFE : 8'hE6; // BRK shares IRQ in emulation.
    endcase
  end

  assign vecByte    = vecLow + 8'(fetchState == FETCH_HIGH);
  assign vectorAddr = VPB ? '0 : addrT'({8'hFF, vecByte});

  noEndInFetch: assert property (@(posedge CLK) disable iff (!RST_N)
    !VPB |-> !instrEnd)
    else $error("instrEnd asserted during a vector fetch");

  vpbMatchesIdle: assert property (@(posedge CLK) disable iff (!RST_N)
    VPB == (fetchState == FETCH_IDLE))
    else $error("VPB out of step with the fetch state");

endmodule

// File: design/cpuIntCtrl.sv
`timescale 1ns/100ps

module cpuIntCtrl
#(
  parameter int AddrW = 24
)
(
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              CE,
  input  logic              RDY_IN,
  input  logic              NMI_N,
  input  logic              IRQ_N,
  input  logic              ABORT_N,
  input  cpuIntPkg::opcodeT opcode,
  input  cpuIntPkg::opcodeT operand,
  input  logic              instrEnd,
  output cpuIntPkg::statusT status,
  output logic              branchTaken,
  output logic [AddrW-1:0]  vectorAddr,
  output logic              VPB,
  output logic              RDY_OUT
);

  logic en;
  logic nmiPending;
  logic irqPending;
  logic takeInt;
  logic nmiAck;

  assign RDY_OUT = en;

  statusReg u_statusReg
  (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .en          (en),
    .instrEnd    (instrEnd),
    .opcode      (opcode),
    .operand     (operand),
    .takeInt     (takeInt),
    .status      (status),
    .branchTaken (branchTaken)
  );

  pinWakeCtrl u_pinWakeCtrl
  (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .CE         (CE),
    .RDY_IN     (RDY_IN),
    .NMI_N      (NMI_N),
    .IRQ_N      (IRQ_N),
    .ABORT_N    (ABORT_N),
    .instrEnd   (instrEnd),
    .opcode     (opcode),
    .nmiAck     (nmiAck),
    .en         (en),
    .nmiPending (nmiPending),
    .irqPending (irqPending)
  );

  vectorArbiter #(.AddrW(AddrW)) u_vectorArbiter
  (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .en         (en),
    .instrEnd   (instrEnd),
    .opcode     (opcode),
    .status     (status),
    .nmiPending (nmiPending),
    .irqPending (irqPending),
    .takeInt    (takeInt),
    .nmiAck     (nmiAck),
    .VPB        (VPB),
    .vectorAddr (vectorAddr)
  );

endmodule

// File: verif/tbStim.svh
`ifndef TB_STIM_SVH
`define TB_STIM_SVH

// One instruction per row. The branch result is taken before the status edge.
typedef struct
{
  string  name;
  opcodeT opc;
  opcodeT opd;
  statusT expStatus;
  logic   expBranch;
} stimRowT;

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Bank 00, then FF, then the low byte of the chosen vector.
function automatic logic [23:0] expectVector(input string cause, input logic emu,
                                             input logic second);
  logic [7:0] low;
  if (cause == "nmi")
    low = emu ? 8'hFA : 8'hEA;
  else if (cause == "irq")
    low = emu ? 8'hFE : 8'hEE;
  else if (cause == "cop")
    low = emu ? 8'hF4 : 8'hE4;
  else if (cause == "brk")
    low = emu ? 8'hFE : 8'hE6;
  else
    low = 8'hFC; // Reset, same in both modes.
  return {8'h00, 8'hFF, low + {7'd0, second}};
endfunction

`endif

// File: verif/cpuIntCtrlTb.sv
`timescale 1ns/100ps

module cpuIntCtrlTb;
  import cpuIntPkg::*;

  `include "tbStim.svh"

  localparam opcodeT NOP = 8'hEA;

  logic        CLK;
  logic        RST_N;
  logic        CE;
  logic        RDY_IN;
  logic        NMI_N;
  logic        IRQ_N;
  logic        ABORT_N;
  opcodeT      opcode;
  opcodeT      operand;
  logic        instrEnd;
  statusT      status;
  logic        branchTaken;
  logic [23:0] vectorAddr;
  logic        VPB;
  logic        RDY_OUT;

  stimRowT     stimTable[$];
  logic [31:0] rngState;
  statusT      model;
  logic        quiet;
  int          errors;
  int          checks;

  cpuIntCtrl #(.AddrW(24)) i_cpuIntCtrl (.*);

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // REP clears and SEP sets the operand bits. M and X are fixed in emulation.
  function automatic statusT repSepRef(input statusT cur, input logic isSep,
                                       input opcodeT mask);
    statusT res;
    opcodeT keep;
    keep = cur[E_BIT] ? (mask & 8'hCF) : mask;
    res = cur;
    res[7:0] = isSep ? (cur[7:0] | keep) : (cur[7:0] & ~keep);
    return res;
  endfunction

  function automatic logic branchRef(input opcodeT opc, input statusT st);
    case (opc)
      8'h10:   return !st[N_BIT]; // BPL.
      8'h30:   return st[N_BIT];
      8'h50:   return !st[V_BIT];
      8'h70:   return st[V_BIT];
      8'h90:   return !st[C_BIT]; // BCC.
      8'hB0:   return st[C_BIT];
      8'hD0:   return !st[Z_BIT];
      8'hF0:   return st[Z_BIT];
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [23:0] expV,
                            input logic [23:0] actV);
    checks++;
    assert (actV === expV)
      else
      begin
        $display("[FAIL] %s: expected %h, actual %h", name, expV, actV);
        errors++;
      end
  endtask

  task automatic addRow(input string name, input opcodeT opc, input opcodeT opd,
                        input statusT expS);
    stimRowT row;
    row.name      = name;
    row.opc       = opc;
    row.opd       = opd;
    row.expStatus = expS;
    row.expBranch = branchRef(opc, model);
    stimTable.push_back(row);
    model = expS;
  endtask

  task automatic addRandomRows(input string prefix, input int count);
    logic isSep;
    for (int i = 0; i < count; i++)
    begin
      rngState = xorshift(rngState);
      isSep = rngState[8];
      addRow($sformatf("%s rep/sep %0d", prefix, i), isSep ? OP_SEP : OP_REP,
             rngState[7:0], repSepRef(model, isSep, rngState[7:0]));
      addRow($sformatf("%s branch %0d", prefix, i), {rngState[18:16], 5'h10}, 8'h00, model);
    end
  endtask

  task automatic buildTable();
    model = 9'h134; // E, M, X and I set.
    addRow("sec", 8'h38, 8'h00, 9'h135);
    addRow("clc in emu", 8'h18, 8'h00, 9'h134);
    addRow("xce to native", OP_XCE, 8'h00, 9'h035);
    addRow("cli", 8'h58, 8'h00, 9'h031);
    addRow("sed", 8'hF8, 8'h00, 9'h039);
    addRow("cld", 8'hD8, 8'h00, 9'h031);
    addRow("sei", 8'h78, 8'h00, 9'h035);
    addRow("clc", 8'h18, 8'h00, 9'h034);
    addRow("sep all", OP_SEP, 8'hFF, 9'h0FF);
    addRow("clv", 8'hB8, 8'h00, 9'h0BF);
    for (int i = 0; i < 8; i++)
      addRow($sformatf("branch nzc %0d", i), {i[2:0], 5'h10}, 8'h00, model);
    addRow("rep all", OP_REP, 8'hFF, 9'h000);
    for (int i = 0; i < 8; i++)
      addRow($sformatf("branch clear %0d", i), {i[2:0], 5'h10}, 8'h00, model);
    addRandomRows("native", 6);
    addRow("sec again", 8'h38, 8'h00, model | 9'h001);
    addRow("xce to emu", OP_XCE, 8'h00, (model & 9'h0FE) | 9'h130); // Old E was 0.
    addRandomRows("emu", 6);
  endtask

  task automatic runRow(input stimRowT row);
    @(posedge CLK);
    opcode   <= row.opc;
    operand  <= row.opd;
    instrEnd <= 1'b1;
    @(negedge CLK);
    checkValue({row.name, " branch"}, row.expBranch, branchTaken);
    @(posedge CLK);
    instrEnd <= 1'b0;
    opcode   <= NOP;
    @(negedge CLK);
    checkValue({row.name, " status"}, row.expStatus, status);
  endtask

  task automatic doInstr(input opcodeT opc, input opcodeT opd);
    @(posedge CLK);
    opcode   <= opc;
    operand  <= opd;
    instrEnd <= 1'b1;
    @(posedge CLK);
    instrEnd <= 1'b0;
    opcode   <= NOP;
  endtask

  task automatic expectFetch(input string name, input string cause, input logic emu);
    int n;
    n = 0;
    @(negedge CLK);
    while (VPB && n < 20)
    begin
      @(negedge CLK);
      n++;
    end
    assert (!VPB)
      else
      begin
        $display("%s: VPB never went low within 20 cycles", name);
        errors++;
      end
    checkValue({name, " low addr"}, expectVector(cause, emu, 1'b0), vectorAddr);
    @(negedge CLK);
    checkValue({name, " high addr"}, expectVector(cause, emu, 1'b1), vectorAddr);
    @(negedge CLK);
    checkValue({name, " vpb back"}, 24'd1, VPB);
  endtask

  task automatic waitRdyOut(input string name, input logic level);
    int n;
    n = 0;
    @(negedge CLK);
    while (RDY_OUT !== level && n < 20)
    begin
      @(negedge CLK);
      n++;
    end
    assert (RDY_OUT === level)
      else
      begin
        $display("%s: RDY_OUT did not reach %b within 20 cycles", name, level);
        errors++;
      end
  endtask

  task automatic applyReset();
    @(posedge CLK);
    RST_N <= 1'b0;
    repeat (8) @(posedge CLK);
    RST_N <= 1'b1;
  endtask

  initial
  begin
    errors   = 0;
    checks   = 0;
    rngState = 32'h1b10;
    RST_N    <= 1'b0;
    CE       <= 1'b1;
    RDY_IN   <= 1'b1;
    NMI_N    <= 1'b1;
    IRQ_N    <= 1'b1;
    ABORT_N  <= 1'b1;
    opcode   <= NOP;
    operand  <= 8'h00;
    instrEnd <= 1'b0;
    buildTable();
    applyReset();
    expectFetch("reset", "reset", 1'b1);
    checkValue("reset status", 24'h134, status);
    foreach (stimTable[i])
      runRow(stimTable[i]);

    // Native mode, D set and I clear before the NMI.
    doInstr(8'h18, 8'h00);
    doInstr(OP_XCE, 8'h00);
    doInstr(OP_SEP, 8'h08);
    doInstr(8'h58, 8'h00);
    @(negedge CLK);
    checkValue("nmi setup", 24'h008, status & 9'h10C);
    @(posedge CLK);
    NMI_N <= 1'b0;
    doInstr(NOP, 8'h00);
    expectFetch("nmi", "nmi", 1'b0);
    checkValue("nmi entry flags", 24'h004, status & 9'h10C);
    @(posedge CLK);
    NMI_N <= 1'b1;
    IRQ_N <= 1'b0; // I is still set from the NMI.
    doInstr(NOP, 8'h00);
    quiet = 1'b1;
    repeat (6)
    begin
      @(negedge CLK);
      quiet &= VPB;
    end
    checkValue("irq masked", 24'd1, quiet);
    doInstr(8'h58, 8'h00);
    doInstr(NOP, 8'h00);
    expectFetch("irq", "irq", 1'b0);
    @(posedge CLK);
    IRQ_N <= 1'b1;

    doInstr(OP_BRK, 8'h00);
    expectFetch("brk native", "brk", 1'b0);
    doInstr(OP_COP, 8'h00);
    expectFetch("cop native", "cop", 1'b0);
    doInstr(8'h38, 8'h00);
    doInstr(OP_XCE, 8'h00);
    doInstr(OP_BRK, 8'h00);
    expectFetch("brk emu", "brk", 1'b1);
    doInstr(OP_COP, 8'h00);
    expectFetch("cop emu", "cop", 1'b1);

    checkValue("wai with i set", 24'd1, status[I_BIT]);
    doInstr(OP_WAI, 8'h00);
    @(negedge CLK);
    checkValue("wai rdy low", 24'd0, RDY_OUT);
    repeat (3) @(posedge CLK);
    IRQ_N <= 1'b0;
    waitRdyOut("wai wake", 1'b1);
    @(posedge CLK);
    IRQ_N <= 1'b1;

    doInstr(OP_STP, 8'h00);
    @(posedge CLK);
    NMI_N <= 1'b0; // No wake from STP.
    quiet = 1'b1;
    repeat (8)
    begin
      @(negedge CLK);
      quiet &= !RDY_OUT;
    end
    checkValue("stp holds through nmi", 24'd1, quiet);
    @(posedge CLK);
    NMI_N <= 1'b1;
    applyReset();
    expectFetch("reset after stp", "reset", 1'b1);
    checkValue("rdy after reset", 24'd1, RDY_OUT);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: cpuIntCtrl.f
+incdir+verif
design/cpuIntPkg.sv
design/statusReg.sv
design/pinWakeCtrl.sv
design/vectorArbiter.sv
design/cpuIntCtrl.sv
verif/cpuIntCtrlTb.sv
